// File: filelist.f
+incdir+include
hw/ppu_pkg.sv
hw/ppu_frame_timing.sv
hw/ppu_regs.sv
hw/ppu_scroll.sv
hw/ppu_bg_fetch.sv
hw/ppu_palette.sv
hw/ppu_top.sv
tests/ppu_properties.sv
tests/ppu_tb.sv

// File: Makefile
# Verilator build and run for the background PPU testbench

VERILATOR ?= verilator
TOP       ?= ppu_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= sim failed
PASS_MSG  ?= sim passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "No result line found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/ppu_tb.sv
/* Testbench for ppu_top with background rendering only. The VRAM model answers 8'hFF
   while the background is on, so the render checks expect solid palette entry 15 */
`timescale 1ns/1ps
`default_nettype none

`include "ppu_macros.svh"

module ppu_tb import ppu_pkg::*; ();

  localparam int FRAME_CYCLES = 341 * 262;
  localparam int CYCLE_LIMIT  = 3 * FRAME_CYCLES + (3 * FRAME_CYCLES) / 10;  // 3 frames + 10%

  logic        clk;
  logic        reset;
  cpu_bus_t    cpu;
  logic [7:0]  dout;
  logic        nmi;
  logic [5:0]  color;
  logic        vram_r;
  logic        vram_w;
  logic [13:0] vram_a;
  logic [7:0]  vram_din = 8'h00;
  logic [7:0]  vram_dout;
  frame_pos_t  pos;

  logic [7:0]  vram [0:16383];   // 16 KiB VRAM model
  logic [5:0]  pal_exp [0:31];   // Expected palette contents
  logic [7:0]  wr_data [$];      // Bytes written through the data port
  logic        bg_on = 1'b0;     // Background enabled by the stimulus
  int          checks = 0;
  int          errors = 0;
  int          cycles = 0;
  logic [7:0]  dout_s;           // Outputs sampled mid-access
  logic        vram_w_s;
  logic [13:0] vram_a_s;

  ppu_top uut (
    .clk       (clk),
    .reset     (reset),
    .cpu       (cpu),
    .dout      (dout),
    .nmi       (nmi),
    .color     (color),
    .vram_r    (vram_r),
    .vram_w    (vram_w),
    .vram_a    (vram_a),
    .vram_din  (vram_din),
    .vram_dout (vram_dout),
    .pos       (pos)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the tests did not finish", cycles);
      $display("sim failed");
      $finish;
    end
  end

  // Read data appears one cycle after vram_r
  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 16384; i++)
        vram[14'(i)] <= 8'($urandom);
    end else begin
      if (vram_r)
        vram_din <= bg_on ? 8'hFF : vram[vram_a];
      if (vram_w)
        vram[vram_a] <= vram_dout;
    end
  end

  task automatic expect_eq(input string name, input int expected, input int actual);
    checks++;
    assert (expected == actual) else begin
      errors++;
      $display("[FAIL] %s: expected 'h%0h, actual 'h%0h", name, expected, actual);
    end
  endtask

  // One CPU access, then one idle cycle; outputs sampled at the falling edge
  task automatic bus_cycle(input logic [2:0] reg_idx, input logic [7:0] data,
                           input logic rd, input logic wr);
    @(posedge clk);
    cpu <= '{ain: reg_idx, din: data, read: rd, write: wr};
    @(negedge clk);
    dout_s   = dout;
    vram_w_s = vram_w;
    vram_a_s = vram_a;
    @(posedge clk);
    cpu <= '0;
  endtask

  task automatic write_reg(input logic [2:0] reg_idx, input logic [7:0] data);
    bus_cycle(reg_idx, data, 1'b0, 1'b1);
  endtask

  task automatic read_reg(input logic [2:0] reg_idx);
    bus_cycle(reg_idx, 8'h00, 1'b1, 1'b0);
  endtask

  task automatic set_address(input logic [13:0] addr);
    read_reg(`PPU_REG_STATUS);   // Clears the write latch
    write_reg(`PPU_REG_ADDR, {2'b00, addr[13:8]});
    write_reg(`PPU_REG_ADDR, addr[7:0]);
  endtask

  // Every fourth entry aliases the backdrop
  function automatic int pal_slot(input int entry);
    return (entry % 4 == 0) ? 0 : entry;
  endfunction

  // Entries 4, 8 and 12 and their copies at 20, 24 and 28 ignore writes
  function automatic bit pal_read_only(input int entry);
    return (entry % 16) inside {4, 8, 12};
  endfunction

  initial begin
    logic [13:0] exp_addr;
    logic [7:0]  val;
    void'($urandom(32'h20b3));
    reset <= 1'b1;
    cpu   <= '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    expect_eq("reset position", 0, int'(pos));
    expect_eq("reset nmi", 0, int'(nmi));

    // Vblank flag and nmi
    write_reg(`PPU_REG_CTRL, 8'h80);
    while (!nmi) @(negedge clk);
    expect_eq("nmi line", 241, int'(pos.scanline));
    expect_eq("nmi cycle", 0, int'(pos.cycle));
    read_reg(`PPU_REG_STATUS);
    expect_eq("status read", 'h80, int'(dout_s));
    @(negedge clk);
    expect_eq("nmi after status read", 0, int'(nmi));

    // Data writes step by 1, then by 32
    write_reg(`PPU_REG_CTRL, 8'h00);
    set_address(14'h2108);
    exp_addr = 14'h2108;
    for (int k = 0; k < 5; k++) begin
      if (k == 3)
        write_reg(`PPU_REG_CTRL, 8'h04);
      val = 8'($urandom);
      wr_data.push_back(val);
      write_reg(`PPU_REG_DATA, val);
      expect_eq("data write strobe", 1, int'(vram_w_s));
      expect_eq("data write address", int'(exp_addr), int'(vram_a_s));
      exp_addr = exp_addr + ((k >= 3) ? 14'd32 : 14'd1);
    end
    // Read back one access late; step switches to 32 before the 210B read
    write_reg(`PPU_REG_CTRL, 8'h00);
    set_address(14'h2108);
    read_reg(`PPU_REG_DATA);   // Primes the buffer
    for (int k = 0; k < 5; k++) begin
      if (k == 2)
        write_reg(`PPU_REG_CTRL, 8'h04);
      read_reg(`PPU_REG_DATA);
      expect_eq("data read back", int'(wr_data[k]), int'(dout_s));
    end

    // Palette sweep with backdrop mirroring and read-only entries
    write_reg(`PPU_REG_CTRL, 8'h00);
    set_address(14'h3F00);
    for (int k = 0; k < 32; k++) begin
      val = 8'($urandom);
      write_reg(`PPU_REG_DATA, val);
      expect_eq("palette write strobe", 0, int'(vram_w_s));
      if (!pal_read_only(k))
        pal_exp[pal_slot(k)] = val[5:0];
    end
    set_address(14'h3F00);
    for (int k = 0; k < 32; k++) begin
      read_reg(`PPU_REG_DATA);
      expect_eq("palette read", int'(pal_exp[pal_slot(k)]), int'(dout_s));
    end
    write_reg(`PPU_REG_MASK, 8'h01);   // Grayscale
    set_address(14'h3F0F);
    read_reg(`PPU_REG_DATA);
    expect_eq("grayscale read", int'(pal_exp[15] & 6'h30), int'(dout_s));
    write_reg(`PPU_REG_MASK, 8'h00);

    // Rendering with clip-show starts at the pre-render line
    set_address(14'h2000);
    bg_on <= 1'b1;
    write_reg(`PPU_REG_MASK, 8'h0A);
    @(negedge clk);
    while (!(pos.scanline == 9'd1 && pos.cycle == 9'd0)) @(negedge clk);
    while (pos.scanline != `PPU_VBL_START_LINE) begin
      if (pos.cycle >= 9'd16 && pos.cycle <= 9'd255)
        expect_eq("background color", int'(pal_exp[15]), int'(color));
      if (!pos.cycle[0] && pos.cycle != `PPU_LAST_CYCLE)
        expect_eq("fetch strobe", 1, int'(vram_r));
      if (pos.cycle[2:1] == 2'b00)
        expect_eq("name fetch page", 2, int'(vram_a[13:12]));
      @(negedge clk);
    end
    write_reg(`PPU_REG_MASK, 8'h00);
    bg_on <= 1'b0;
    // Full-length pre-render line with rendering off, then into line 0
    while (!(pos.scanline == 9'd0 && pos.cycle == 9'd2)) @(negedge clk);

    $display("checks: %0d, compare errors: %0d, assertion errors: %0d",
             checks, errors, uut.props.fail_count);
    if (errors == 0 && uut.props.fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/ppu_properties.sv
/* Concurrent checks on the ppu_top ports, bound into ppu_top.
   fail_count holds the number of failed assertions for the testbench */
`timescale 1ns/1ps
`default_nettype none

`include "ppu_macros.svh"

module ppu_properties import ppu_pkg::*; (
  input logic        clk,
  input logic        reset,
  input cpu_bus_t    cpu,
  input logic        nmi,
  input logic        vram_r,
  input logic        vram_w,
  input logic [13:0] vram_a,
  input frame_pos_t  pos
);

  int fail_count = 0;

  // Line wrap; a short pre-render line never reaches cycle 340
  ap_cycle_wrap: assert property (@(posedge clk) disable iff (reset)
    pos.cycle == `PPU_LAST_CYCLE |=> pos.cycle == 9'd0)
    else begin fail_count++; $error("cycle did not wrap to 0 after 340"); end

  ap_to_prerender: assert property (@(posedge clk) disable iff (reset)
    pos.scanline == `PPU_VBL_END_LINE && pos.cycle == `PPU_LAST_CYCLE |=> pos.scanline == 9'h1FF)
    else begin fail_count++; $error("scanline 260 not followed by pre-render"); end

  ap_to_first_line: assert property (@(posedge clk) disable iff (reset)
    pos.scanline == 9'h1FF && pos.cycle == `PPU_LAST_CYCLE |=> pos.scanline == 9'd0)
    else begin fail_count++; $error("pre-render line not followed by line 0"); end

  // nmi rises with vblank, or when vbl_enable is written while the flag is up
  ap_nmi_rise: assert property (@(posedge clk) disable iff (reset)
    $rose(nmi) |-> (pos.scanline == 9'd241 && pos.cycle == 9'd0) ||
                   $past(cpu.write && cpu.ain == `PPU_REG_CTRL))
    else begin fail_count++; $error("nmi rose away from line 241 cycle 0"); end

  ap_status_clears: assert property (@(posedge clk) disable iff (reset)
    cpu.read && cpu.ain == `PPU_REG_STATUS |=> !nmi)
    else begin fail_count++; $error("nmi still high after a status read"); end

  ap_no_pal_write: assert property (@(posedge clk) disable iff (reset)
    vram_w |-> vram_a[13:8] != `PPU_PAL_PAGE)
    else begin fail_count++; $error("VRAM write strobe in palette space"); end

  ap_reset_quiet: assert property (@(posedge clk)
    reset |=> !nmi && !vram_w && !vram_r)
    else begin fail_count++; $error("strobes or nmi active after reset"); end

endmodule

bind ppu_top ppu_properties props (
  .clk    (clk),
  .reset  (reset),
  .cpu    (cpu),
  .nmi    (nmi),
  .vram_r (vram_r),
  .vram_w (vram_w),
  .vram_a (vram_a),
  .pos    (pos)
);

`default_nettype wire

// File: hw/ppu_top.sv
/* Background-only PPU, one pixel per clk. No sprites, no clock enable.
   vram_a shows the current address outside rendering, the fetch address during it */
`timescale 1ns/1ps
`default_nettype none

`include "ppu_macros.svh"

module ppu_top import ppu_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  cpu_bus_t                cpu,
  output logic [7:0]              dout,
  output logic                    nmi,
  output logic [`PPU_COLOR_W-1:0] color,
  output logic                    vram_r,
  output logic                    vram_w,
  output logic [`PPU_BUS_AW-1:0]  vram_a,
  input  logic [7:0]              vram_din,
  output logic [7:0]              vram_dout,
  output frame_pos_t              pos
);

  frame_evt_t  evt;
  ppu_ctrl_t   ctrl;
  ppu_mask_t   mask;
  scroll_cmd_t scmd;
  vram_addr_t  v;
  logic [2:0]  fine_x;
  logic        pal_sel;
  logic [`PPU_BUS_AW-1:0] fetch_addr;
  logic [3:0]  bg_pixel;
  logic [4:0]  pal_addr;
  logic        pal_we;
  logic        is_rendering;

  // Line 240 is idle even with the background on
  assign is_rendering = mask.bg_enable && !evt.in_vblank &&
                        (pos.scanline != `PPU_VBL_START_LINE);

  assign vram_a    = is_rendering ? fetch_addr : v[`PPU_BUS_AW-1:0];
  assign vram_dout = cpu.din;

  // Pixel while drawing, CPU address in the palette page, else backdrop
  assign pal_addr = is_rendering ? {1'b0, bg_pixel} : (pal_sel ? v[4:0] : 5'd0);
  assign pal_we   = scmd.data_access && cpu.write && pal_sel;

  ppu_frame_timing u_timing (
    .clk          (clk),
    .reset        (reset),
    .is_rendering (is_rendering),
    .pos          (pos),
    .evt          (evt)
  );

  ppu_regs u_regs (
    .clk          (clk),
    .reset        (reset),
    .cpu          (cpu),
    .evt          (evt),
    .pal_sel      (pal_sel),
    .is_rendering (is_rendering),
    .vram_din     (vram_din),
    .color        (color),
    .ctrl         (ctrl),
    .mask         (mask),
    .scmd         (scmd),
    .vram_r       (vram_r),
    .vram_w       (vram_w),
    .dout         (dout),
    .nmi          (nmi)
  );

  ppu_scroll u_scroll (
    .clk          (clk),
    .reset        (reset),
    .scmd         (scmd),
    .din          (cpu.din),
    .ctrl         (ctrl),
    .evt          (evt),
    .pos          (pos),
    .is_rendering (is_rendering),
    .v            (v),
    .fine_x       (fine_x),
    .pal_sel      (pal_sel)
  );

  ppu_bg_fetch u_bg (
    .clk          (clk),
    .reset        (reset),
    .pos          (pos),
    .evt          (evt),
    .v            (v),
    .fine_x       (fine_x),
    .ctrl         (ctrl),
    .mask         (mask),
    .is_rendering (is_rendering),
    .vram_din     (vram_din),
    .fetch_addr   (fetch_addr),
    .bg_pixel     (bg_pixel)
  );

  ppu_palette u_palette (
    .clk       (clk),
    .addr      (pal_addr),
    .din       (cpu.din[`PPU_COLOR_W-1:0]),
    .we        (pal_we),
    .grayscale (mask.grayscale),
    .color     (color)
  );

endmodule

`default_nettype wire

// File: hw/ppu_palette.sv
/* 32-entry palette RAM, no reset and no initial contents.
   Read is combinational, write lands at the clock edge */
`timescale 1ns/1ps
`default_nettype none

`include "ppu_macros.svh"

module ppu_palette (
  input  logic                    clk,
  input  logic [4:0]              addr,
  input  logic [`PPU_COLOR_W-1:0] din,
  input  logic                    we,
  input  logic                    grayscale,
  output logic [`PPU_COLOR_W-1:0] color
);

  logic [`PPU_COLOR_W-1:0] mem [0:31];
  logic [4:0]              eff_addr;   // After backdrop mirroring
  logic [`PPU_COLOR_W-1:0] raw;

  // Every x0 entry maps onto the backdrop
  assign eff_addr = (addr[1:0] == 2'b00) ? 5'd0 : addr;
  assign raw      = mem[eff_addr];
  assign color    = grayscale ? {raw[5:4], 4'b0000} : raw;   // Keep luma only

  always_ff @(posedge clk) begin
    // Entries 4, 8, 12 and their mirrors are read-only
    if (we && !(addr[3:2] != 2'b00 && addr[1:0] == 2'b00))
      mem[eff_addr] <= din;
  end

endmodule

`default_nettype wire

// File: hw/ppu_bg_fetch.sv
/* Background tile fetch and pixel shifters, frozen while rendering is off.
   The second pattern byte is not stored; it is loaded live from vram_din at phase 7 */
`timescale 1ns/1ps
`default_nettype none

`include "ppu_macros.svh"

module ppu_bg_fetch import ppu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  frame_pos_t pos,
  input  frame_evt_t evt,
  input  vram_addr_t v,
  input  logic [2:0] fine_x,
  input  ppu_ctrl_t  ctrl,
  input  ppu_mask_t  mask,
  input  logic       is_rendering,
  input  logic [7:0] vram_din,
  output logic [`PPU_BUS_AW-1:0] fetch_addr,
  output logic [3:0] bg_pixel
);

  logic [2:0]  phase;
  logic [7:0]  name_byte;
  logic [1:0]  attr_bits;   // Quadrant of the attribute byte
  logic [7:0]  patt_lo;
  logic [15:0] shift_lo;
  logic [15:0] shift_hi;
  logic [8:0]  shift_a0;
  logic [8:0]  shift_a1;
  logic        shift_en;
  logic        show_bg;
  logic [3:0]  idx;

  assign phase    = pos.cycle[2:0];
  assign shift_en = is_rendering && !evt.last_group;

  always_comb begin
    case (phase[2:1])
      2'd0:    fetch_addr = {2'b10, v[11:0]};                               // Name
      2'd1:    fetch_addr = {2'b10, v[11:10], 4'b1111, v[9:7], v[4:2]};     // Attribute
      default: fetch_addr = {1'b0, ctrl.bg_patt, name_byte, phase[1], v[14:12]};  // Pattern
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      name_byte <= '0;
      attr_bits <= '0;
      patt_lo   <= '0;
      shift_lo  <= '0;
      shift_hi  <= '0;
      shift_a0  <= '0;
      shift_a1  <= '0;
    end else if (is_rendering) begin
      case (phase)
        3'd1: name_byte <= vram_din;
        3'd3: begin
          case ({v[6], v[1]})      // Coarse Y bit 1, coarse X bit 1
            2'b00:   attr_bits <= vram_din[1:0];
            2'b01:   attr_bits <= vram_din[3:2];
            2'b10:   attr_bits <= vram_din[5:4];
            default: attr_bits <= vram_din[7:6];
          endcase
        end
        3'd5: patt_lo <= vram_din;
        default: ;
      endcase
      if (shift_en) begin
        shift_lo[14:0] <= shift_lo[15:1];
        shift_hi[14:0] <= shift_hi[15:1];
        shift_a0[7:0]  <= shift_a0[8:1];
        shift_a1[7:0]  <= shift_a1[8:1];
        if (phase == 3'd7) begin
          // Leftmost pixel is bit 7, so reverse into the LSB-first pipe
          shift_lo[15:8] <= {<<{patt_lo}};
          shift_hi[15:8] <= {<<{vram_din}};
          shift_a0[8]    <= attr_bits[0];
          shift_a1[8]    <= attr_bits[1];
        end
      end
    end
  end

  assign idx = {1'b0, fine_x};
  // Left 8 columns blanked unless clip-show
  assign show_bg = (mask.bg_clip_show || pos.cycle[7:3] != 5'd0) && mask.bg_enable;
  assign bg_pixel = {shift_a1[idx], shift_a0[idx],
                     show_bg ? {shift_hi[idx], shift_lo[idx]} : 2'b00};

endmodule

`default_nettype wire

// File: hw/ppu_scroll.sv
/* Temporary and current VRAM address with fine X and the shared write latch.
   Coarse Y wraps at row 29 only; rows 30 and 31 count on to 0 without a table switch */
`timescale 1ns/1ps
`default_nettype none

`include "ppu_macros.svh"

module ppu_scroll import ppu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  scroll_cmd_t scmd,
  input  logic [7:0]  din,
  input  ppu_ctrl_t   ctrl,
  input  frame_evt_t  evt,
  input  frame_pos_t  pos,
  input  logic        is_rendering,
  output vram_addr_t  v,
  output logic [2:0]  fine_x,
  output logic        pal_sel
);

  vram_addr_t t;        // Temporary address
  logic       w_latch;  // Second write pending
  logic       fetch_win;

  // Tile fetch windows, visible part and next-line prefetch
  assign fetch_win = (pos.cycle < `PPU_HRESET_CYCLE) ||
                     (pos.cycle >= 9'd320 && pos.cycle < 9'd336);
  assign pal_sel = (v[13:8] == `PPU_PAL_PAGE);

  always_ff @(posedge clk) begin
    if (reset) begin
      v       <= '0;
      t       <= '0;
      fine_x  <= '0;
      w_latch <= 1'b0;
    end else begin
      if (is_rendering) begin
        // Coarse X step after the attribute fetch
        if (pos.cycle[2:0] == 3'd3 && fetch_win) begin
          v[4:0] <= v[4:0] + 5'd1;
          v[10]  <= v[10] ^ (v[4:0] == 5'd31);
        end
        if (pos.cycle == `PPU_VINC_CYCLE) begin
          v[14:12] <= v[14:12] + 3'd1;   // Fine Y
          if (v[14:12] == 3'd7) begin
            if (v[9:5] == 5'd29) begin
              v[9:5] <= 5'd0;
              v[11]  <= ~v[11];          // Next table down
            end else begin
              v[9:5] <= v[9:5] + 5'd1;
            end
          end
        end
        if (pos.cycle == `PPU_HRESET_CYCLE)
          {v[10], v[4:0]} <= {t[10], t[4:0]};
        if (pos.cycle == `PPU_VCOPY_CYCLE && evt.pre_render)
          v <= t;   // Full reload for the new frame
      end
      // CPU side, overrides the render updates
      if (scmd.wr_ctrl) begin
        t[11:10] <= din[1:0];  // Name table select
      end else if (scmd.wr_scroll) begin
        if (!w_latch) begin
          t[4:0] <= din[7:3];
          fine_x <= din[2:0];
        end else begin
          t[9:5]   <= din[7:3];
          t[14:12] <= din[2:0];
        end
        w_latch <= ~w_latch;
      end else if (scmd.wr_addr) begin
        if (!w_latch) begin
          t[13:8] <= din[5:0];
          t[14]   <= 1'b0;
        end else begin
          t[7:0] <= din;
          v      <= {t[14:8], din};
        end
        w_latch <= ~w_latch;
      end else if (scmd.status_read) begin
        w_latch <= 1'b0;
      end else if (scmd.data_access && !is_rendering) begin
        v <= v + (ctrl.incr_32 ? 15'd32 : 15'd1);
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/ppu_regs.sv
/* CPU register file. No handshake: read and write are one-cycle strobes.
   Status returns only the vblank flag. Data reads see the buffer one access late */
`timescale 1ns/1ps
`default_nettype none

`include "ppu_macros.svh"

module ppu_regs import ppu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  cpu_bus_t    cpu,
  input  frame_evt_t  evt,
  input  logic        pal_sel,
  input  logic        is_rendering,
  input  logic [7:0]  vram_din,
  input  logic [`PPU_COLOR_W-1:0] color,
  output ppu_ctrl_t   ctrl,
  output ppu_mask_t   mask,
  output scroll_cmd_t scmd,
  output logic        vram_r,
  output logic        vram_w,
  output logic [7:0]  dout,
  output logic        nmi
);

  logic       vbl_flag;    // Set entering vblank
  logic [7:0] read_buf;    // Delayed data port
  logic       read_pend;   // vram_r seen last cycle
  logic       cycle_odd;   // Beam cycle parity
  logic       data_rd;
  logic       data_wr;

  assign data_rd = cpu.read && (cpu.ain == `PPU_REG_DATA);
  assign data_wr = cpu.write && (cpu.ain == `PPU_REG_DATA);

  assign scmd.wr_ctrl     = cpu.write && (cpu.ain == `PPU_REG_CTRL);
  assign scmd.wr_scroll   = cpu.write && (cpu.ain == `PPU_REG_SCROLL);
  assign scmd.wr_addr     = cpu.write && (cpu.ain == `PPU_REG_ADDR);
  assign scmd.data_access = data_rd || data_wr;
  assign scmd.status_read = cpu.read && (cpu.ain == `PPU_REG_STATUS);

  // Fetches use every even cycle except end of line
  assign vram_r = data_rd || (is_rendering && !cycle_odd && !evt.end_of_line);
  assign vram_w = data_wr && !pal_sel && !is_rendering;   // Palette writes go to the RAM

  assign nmi = vbl_flag && ctrl.vbl_enable;

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl      <= '0;
      mask      <= '0;
      vbl_flag  <= 1'b0;
      read_buf  <= '0;
      read_pend <= 1'b0;
      cycle_odd <= 1'b0;
    end else begin
      if (scmd.wr_ctrl) begin
        ctrl.vbl_enable <= cpu.din[7];
        ctrl.bg_patt    <= cpu.din[4];
        ctrl.incr_32    <= cpu.din[2];
      end
      if (cpu.write && (cpu.ain == `PPU_REG_MASK)) begin
        mask.grayscale    <= cpu.din[0];
        mask.bg_clip_show <= cpu.din[1];
        mask.bg_enable    <= cpu.din[3];
      end
      if (evt.exiting_vblank)
        vbl_flag <= 1'b0;
      if (evt.entering_vblank)
        vbl_flag <= 1'b1;
      if (scmd.status_read)  // Read clears, wins over set
        vbl_flag <= 1'b0;
      // Data is on the bus one cycle after vram_r
      read_pend <= vram_r;
      if (read_pend)
        read_buf <= vram_din;
      cycle_odd <= evt.end_of_line ? 1'b0 : ~cycle_odd;  // Follows cycle[0]
    end
  end

  always_comb begin
    case (cpu.ain)
      `PPU_REG_STATUS: dout = {vbl_flag, 7'b0};
      default:         dout = pal_sel ? {2'b00, color} : read_buf;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/ppu_frame_timing.sv
/* Beam counters. Events are combinational from the counters.
   Reset starts at scanline 0 inside vblank, so the first frame is blank */
`timescale 1ns/1ps
`default_nettype none

`include "ppu_macros.svh"

module ppu_frame_timing import ppu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       is_rendering,
  output frame_pos_t pos,
  output frame_evt_t evt
);

  logic [`PPU_POS_W-1:0] cycle;
  logic [`PPU_POS_W-1:0] scanline;
  logic [`PPU_POS_W-1:0] last_cycle;
  logic in_vblank;
  logic odd_frame;    // Toggles once per frame
  logic pre_render;
  logic short_line;
  logic end_of_line;

  assign pre_render = (scanline == '1);
  // Odd frames drop one cycle of the pre-render line
  assign short_line = pre_render && odd_frame && is_rendering;
  assign last_cycle = short_line ? `PPU_LAST_CYCLE - 9'd1 : `PPU_LAST_CYCLE;
  assign end_of_line = (cycle == last_cycle);

  assign evt.end_of_line     = end_of_line;
  assign evt.last_group      = (cycle[8:3] == `PPU_LAST_GROUP);
  assign evt.entering_vblank = end_of_line && (scanline == `PPU_VBL_START_LINE);
  assign evt.exiting_vblank  = end_of_line && (scanline == `PPU_VBL_END_LINE);
  assign evt.in_vblank       = in_vblank;
  assign evt.pre_render      = pre_render;

  assign pos.scanline = scanline;
  assign pos.cycle    = cycle;

  always_ff @(posedge clk) begin
    if (reset) begin
      cycle     <= '0;
      scanline  <= '0;
      in_vblank <= 1'b1;
      odd_frame <= 1'b0;
    end else begin
      cycle <= end_of_line ? '0 : cycle + 9'd1;
      if (evt.entering_vblank)
        in_vblank <= 1'b1;
      else if (evt.exiting_vblank)
        in_vblank <= 1'b0;
      if (end_of_line) begin
        // 260 wraps to the pre-render line, all-ones wraps to 0
        scanline <= evt.exiting_vblank ? '1 : scanline + 9'd1;
        if (evt.exiting_vblank)
          odd_frame <= ~odd_frame;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/ppu_pkg.sv
/* Shared struct types of the background PPU */
`default_nettype none

`include "ppu_macros.svh"

package ppu_pkg;

  typedef struct packed {
    logic [2:0] ain;    // Register index
    logic [7:0] din;
    logic       read;
    logic       write;
  } cpu_bus_t;

  typedef struct packed {
    logic [`PPU_POS_W-1:0] scanline;  // All-ones is pre-render
    logic [`PPU_POS_W-1:0] cycle;
  } frame_pos_t;

  typedef struct packed {
    logic end_of_line;      // Last cycle of the line
    logic last_group;       // Cycles 336 and up
    logic entering_vblank;
    logic exiting_vblank;
    logic in_vblank;        // Level
    logic pre_render;       // Level
  } frame_evt_t;

  typedef struct packed {
    logic vbl_enable;  // NMI on vblank
    logic bg_patt;     // Background pattern table
    logic incr_32;     // Data port step of 32
  } ppu_ctrl_t;

  typedef struct packed {
    logic grayscale;
    logic bg_clip_show;  // Show left 8 columns
    logic bg_enable;
  } ppu_mask_t;

  // Single-cycle pulses, asserted with the CPU access
  typedef struct packed {
    logic wr_ctrl;
    logic wr_scroll;
    logic wr_addr;
    logic data_access;
    logic status_read;
  } scroll_cmd_t;

  typedef logic [`PPU_VADDR_W-1:0] vram_addr_t;

endpackage

`default_nettype wire

// File: include/ppu_macros.svh
/* Constants for the background PPU. Geometry values are sized to the counter widths.
   Line timing assumes 341 cycles per line and 262 lines per frame */
`ifndef PPU_MACROS_SVH
`define PPU_MACROS_SVH

// Widths
`define PPU_POS_W    9   // Cycle and scanline counters
`define PPU_VADDR_W  15  // Scroll register width
`define PPU_BUS_AW   14  // VRAM bus address width
`define PPU_COLOR_W  6   // Palette entry width

// Line and frame geometry
`define PPU_LAST_CYCLE      9'd340
`define PPU_LAST_GROUP      6'd42   // Cycles 336..340
`define PPU_VBL_START_LINE  9'd240
`define PPU_VBL_END_LINE    9'd260

// Scroll copy and increment points
`define PPU_HRESET_CYCLE  9'd256
`define PPU_VINC_CYCLE    9'd251
`define PPU_VCOPY_CYCLE   9'd304

// CPU register indices
`define PPU_REG_CTRL    3'd0
`define PPU_REG_MASK    3'd1
`define PPU_REG_STATUS  3'd2
`define PPU_REG_SCROLL  3'd5
`define PPU_REG_ADDR    3'd6
`define PPU_REG_DATA    3'd7

// High address bits of the palette page
`define PPU_PAL_PAGE  6'h3F

`endif
